//--- all.f
+incdir+logic
logic/pke_enc_pkg.sv
logic/enc_sequencer.sv
logic/seed_input_fsm.sv
logic/hash_stage_fsm.sv
logic/cbd_stage_fsm.sv
logic/ntt_stage_fsm.sv
logic/pke_enc_top.sv
verif/pke_enc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pke_enc_tb -f all.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/Vpke_enc_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
exit 1

//--- verif/pke_enc_tb.sv
`include "pke_enc_cfg.svh"

module pke_enc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ROWS    = 4;
  localparam int TAIL_CYCLES = 50;
  localparam int READY_DELAY = 3; // Datapath init after reset

  logic clk, reset, set;
  logic seed_full, hash_readin_ok, hash_done, cbd_ok_in, cbd_ok_out, ntt_done, sink_ready;
  logic seed_load, hash_set, hash_readin, hash_full_in, hash_readout;
  logic cbd_set, cbd_readin, cbd_readout;
  logic ntt_set, ntt_readin, ntt_cal_en, ntt_readout, done;
  pke_enc_pkg::input_type_e input_type;

  // Responder delays, CBD burst, sink delay and set gaps per scenario
  int row_seed_d [NUM_ROWS] = '{2, 1, 5, 3};
  int row_hash_d [NUM_ROWS] = '{6, 1, 12, 3};
  int row_ntt_d  [NUM_ROWS] = '{4, 1, 9, 2};
  int row_cbd_d  [NUM_ROWS] = '{3, 1, 4, 2};
  int row_burst  [NUM_ROWS] = '{8, 1, 20, 64};
  int row_sink_d [NUM_ROWS] = '{1, 1, 30, 7};
  int row_gaps   [NUM_ROWS] = '{0, 0, 1, 1};

  integer      seed = 77131;
  int          row, cycle_count, cycle_limit, error_count;
  int          load_cnt, full_cnt, hash_words, hash_bursts, ntt_words, ntt_bursts;
  int          cbd_words, cbd_total, ready_cnt;
  int          seed_cnt, hash_cnt, cbd_cnt, ntt_cnt, sink_cnt;
  logic        cal_phase, seen_load, applied_set;
  logic        prev_seed_load, prev_full, prev_hash_readout, prev_cbd_readin;
  logic        prev_ntt_set, prev_cal_en, prev_ntt_readout;
  logic [16:0] prev_outs;

  pke_enc_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [16:0] output_word();
    return {seed_load, input_type, hash_set, hash_readin, hash_full_in, hash_readout,
            cbd_set, cbd_readin, cbd_readout, ntt_set, ntt_readin, ntt_cal_en,
            ntt_readout, done};
  endfunction

  function automatic logic [8:0] strobe_word();
    return {seed_load, hash_readin, hash_full_in, hash_readout, cbd_readin, cbd_readout,
            ntt_readin, ntt_cal_en, ntt_readout};
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("Test failures found");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      error_count++;
      $display("%s (time %0t)", what, $time);
      $display("Test failures found");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic check_reset_state();
    check_value("done", 0, int'(done));
    check_value("strobes", 0, int'(strobe_word()));
    check_value("input_type", int'(pke_enc_pkg::TYPE_NONE), int'(input_type));
    check_value("hash_set", 1, int'(hash_set));
    check_value("cbd_set", 1, int'(cbd_set));
    check_value("ntt_set", 1, int'(ntt_set));
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    set = 1'b1;
    {seed_full, hash_readin_ok, hash_done, cbd_ok_in} = '0;
    {cbd_ok_out, ntt_done, sink_ready} = '0;
    {load_cnt, full_cnt, hash_words, hash_bursts, ntt_words, ntt_bursts} = '0;
    {cbd_words, cbd_total, ready_cnt} = '0;
    {seed_cnt, hash_cnt, cbd_cnt, ntt_cnt, sink_cnt} = '0;
    {cal_phase, seen_load} = '0;
    {prev_seed_load, prev_full, prev_hash_readout, prev_cbd_readin} = '0;
    {prev_ntt_set, prev_cal_en, prev_ntt_readout} = '0;
    repeat (2) begin
      @(negedge clk);
      check_reset_state();
    end
    reset = 1'b0;
    applied_set = 1'b1;
    prev_outs = output_word();
  endtask

  // Datapath models answering the controller strobes
  task automatic update_responders();
    if (ready_cnt < READY_DELAY) begin
      ready_cnt++;
      if (ready_cnt == READY_DELAY) {hash_readin_ok, cbd_ok_in} = 2'b11;
    end
    if (seed_cnt > 0) begin
      seed_cnt--;
      if (seed_cnt == 0) seed_full = 1'b1;
    end
    if (hash_cnt > 0) begin
      hash_cnt--;
      if (hash_cnt == 0) hash_done = 1'b1;
    end
    if (cbd_cnt > 0) begin
      cbd_cnt--;
      if (cbd_cnt == 0) cbd_ok_out = 1'b1;
    end
    if (sink_cnt > 0) begin
      sink_cnt--;
      if (sink_cnt == 0) sink_ready = 1'b1;
    end
    if (ntt_cnt > 0) begin
      ntt_cnt--;
      if (ntt_cnt == 0) begin
        ntt_done = 1'b1;
        if (cal_phase) begin
          cal_phase = 1'b0;
          sink_cnt = row_sink_d[row]; // Sink wakes up once the transform is done
        end
      end
    end
    if (seed_load && !prev_seed_load) seed_cnt = row_seed_d[row];
    if (hash_full_in && !prev_full) begin
      hash_done = 1'b0;
      hash_cnt = row_hash_d[row];
    end
    if (prev_cbd_readin && !cbd_readin) cbd_cnt = row_cbd_d[row];
    if ((ntt_set && !prev_ntt_set) || (ntt_cal_en && !prev_cal_en)) begin
      ntt_done = 1'b0;
      ntt_cnt = row_ntt_d[row];
      cal_phase = ntt_cal_en;
    end
  endtask

  task automatic run_cycle();
    logic [16:0] cur;
    logic        new_set;
    @(negedge clk);
    cycle_count++;
    check_true(cycle_count <= cycle_limit, "Timeout: the encryption run never finished");
    cur = output_word();
    new_set = 1'b1;
    if (row_gaps[row] != 0) new_set = (($random(seed) & 3) != 0);
    if (!applied_set) check_value("outputs while set low", int'(prev_outs), int'(cur));
    if (seen_load)
      check_value("input_type", int'(pke_enc_pkg::TYPE_HASH_SEED), int'(input_type));
    if (new_set) begin // This cycle counts only if the next edge is enabled
      if (seed_load) load_cnt++;
      if (hash_full_in) full_cnt++;
      if (hash_readout) hash_words++;
      if (ntt_readout) ntt_words++;
      if (cbd_readout) begin
        cbd_total++;
        cbd_words++;
        if (cbd_words == row_burst[row]) begin
          cbd_ok_out = 1'b0; // Sampler drained
          cbd_words = 0;
        end
      end
    end
    if (seed_load) seen_load = 1'b1;
    if (prev_hash_readout && !hash_readout) begin
      check_value("hash_readout burst length", `PKE_HASH_OUT_WORDS, hash_words);
      hash_bursts++;
      hash_words = 0;
    end
    if (ntt_readout && !prev_ntt_readout)
      check_true(sink_ready, "ntt_readout rose while sink_ready was low");
    if (prev_ntt_readout && !ntt_readout) begin
      check_value("ntt_readout burst length", `PKE_POLY_OUT_WORDS, ntt_words);
      ntt_bursts++;
      ntt_words = 0;
      sink_ready = 1'b0;
    end
    update_responders();
    {prev_seed_load, prev_full, prev_hash_readout} = {seed_load, hash_full_in, hash_readout};
    {prev_cbd_readin, prev_ntt_set} = {cbd_readin, ntt_set};
    {prev_cal_en, prev_ntt_readout} = {ntt_cal_en, ntt_readout};
    set = new_set;
    applied_set = new_set;
    prev_outs = cur;
  endtask

  initial begin
    int row_len;
    {reset, set} = 2'b11;
    {seed_full, hash_readin_ok, hash_done, cbd_ok_in} = '0;
    {cbd_ok_out, ntt_done, sink_ready} = '0;
    cycle_count = 0;
    error_count = 0;
    cycle_limit = 0;
    row = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      row_len = row_seed_d[i] + 40 + TAIL_CYCLES + `PKE_ENC_ROUNDS *
                (row_hash_d[i] + row_cbd_d[i] + 2 * row_ntt_d[i] + row_burst[i] +
                 row_sink_d[i] + `PKE_HASH_OUT_WORDS + `PKE_POLY_OUT_WORDS + 40);
      cycle_limit += (row_gaps[i] != 0) ? 4 * row_len : 2 * row_len;
    end
    for (row = 0; row < NUM_ROWS; row++) begin
      apply_reset();
      while (!done) run_cycle();
      check_value("hash_readout bursts", `PKE_ENC_ROUNDS, hash_bursts);
      check_value("hash_full_in pulses", `PKE_ENC_ROUNDS, full_cnt);
      check_value("seed_load cycles", 1, load_cnt);
      check_value("ntt_readout bursts", `PKE_ENC_ROUNDS, ntt_bursts);
      check_value("cbd_readout cycles", `PKE_ENC_ROUNDS * row_burst[row], cbd_total);
      repeat (TAIL_CYCLES) begin
        run_cycle();
        check_value("done after completion", 1, int'(done));
        check_value("strobes after done", 0, int'(strobe_word()));
      end
    end
    if (error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "Errors were recorded");
    end
  end

endmodule

//--- logic/pke_enc_top.sv
module pke_enc_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     set,
  input  logic                     seed_full,
  input  logic                     hash_readin_ok,
  input  logic                     hash_done,
  input  logic                     cbd_ok_in,
  input  logic                     cbd_ok_out,
  input  logic                     ntt_done,
  input  logic                     sink_ready,
  output logic                     seed_load,
  output pke_enc_pkg::input_type_e input_type,
  output logic                     hash_set,
  output logic                     hash_readin,
  output logic                     hash_full_in,
  output logic                     hash_readout,
  output logic                     cbd_set,
  output logic                     cbd_readin,
  output logic                     cbd_readout,
  output logic                     ntt_set,
  output logic                     ntt_readin,
  output logic                     ntt_cal_en,
  output logic                     ntt_readout,
  output logic                     done
);

  // Commands from the sequencer
  pke_enc_pkg::ctrl_cmd_e seed_cmd;
  pke_enc_pkg::ctrl_cmd_e hash_cmd;
  pke_enc_pkg::ctrl_cmd_e cbd_cmd;
  pke_enc_pkg::ctrl_cmd_e ntt_cmd;

  pke_enc_pkg::input_status_e seed_status;
  pke_enc_pkg::stage_status_e hash_status; // Producer
  pke_enc_pkg::stage_status_e cbd_status;  // Buffer
  pke_enc_pkg::stage_status_e ntt_status;  // Consumer

  enc_sequencer u_seq (
    .clk(clk), .reset(reset), .set(set),
    .seed_status(seed_status), .hash_status(hash_status),
    .cbd_status(cbd_status), .ntt_status(ntt_status),
    .seed_cmd(seed_cmd), .hash_cmd(hash_cmd), .cbd_cmd(cbd_cmd), .ntt_cmd(ntt_cmd),
    .done(done)
  );

  seed_input_fsm u_seed (
    .clk(clk), .reset(reset), .set(set),
    .seed_cmd(seed_cmd), .hash_status(hash_status), .seed_full(seed_full),
    .seed_status(seed_status), .input_type(input_type), .seed_load(seed_load)
  );

  hash_stage_fsm u_hash (
    .clk(clk), .reset(reset), .set(set),
    .hash_cmd(hash_cmd), .seed_status(seed_status), .cbd_status(cbd_status),
    .hash_readin_ok(hash_readin_ok), .hash_done(hash_done),
    .hash_status(hash_status), .hash_set(hash_set), .hash_readin(hash_readin),
    .hash_full_in(hash_full_in), .hash_readout(hash_readout)
  );

  cbd_stage_fsm u_cbd (
    .clk(clk), .reset(reset), .set(set),
    .cbd_cmd(cbd_cmd), .hash_status(hash_status), .ntt_status(ntt_status),
    .cbd_ok_in(cbd_ok_in), .cbd_ok_out(cbd_ok_out),
    .cbd_status(cbd_status), .cbd_set(cbd_set), .cbd_readin(cbd_readin),
    .cbd_readout(cbd_readout)
  );

  ntt_stage_fsm u_ntt (
    .clk(clk), .reset(reset), .set(set),
    .ntt_cmd(ntt_cmd), .cbd_status(cbd_status), .ntt_done(ntt_done),
    .sink_ready(sink_ready),
    .ntt_status(ntt_status), .ntt_set(ntt_set), .ntt_readin(ntt_readin),
    .ntt_cal_en(ntt_cal_en), .ntt_readout(ntt_readout)
  );

endmodule

//--- logic/ntt_stage_fsm.sv
`include "pke_enc_cfg.svh"

module ntt_stage_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set,
  input  pke_enc_pkg::ctrl_cmd_e     ntt_cmd,
  input  pke_enc_pkg::stage_status_e cbd_status,
  input  logic                       ntt_done,
  input  logic                       sink_ready,
  output pke_enc_pkg::stage_status_e ntt_status,
  output logic                       ntt_set,
  output logic                       ntt_readin,
  output logic                       ntt_cal_en,
  output logic                       ntt_readout
);

  localparam int ROUND_W = $clog2(`PKE_ENC_ROUNDS + 1);
  localparam int WORD_W  = $clog2(`PKE_POLY_OUT_WORDS);

  typedef enum logic [3:0] {
    IDLE, READY_INPUT, INPUT, START_CAL, CALCULATE,
    OUTPUT_READY, OUTPUT, OUTPUT_DONE, SEQ_DONE
  } state_e;

  state_e             state;
  state_e             state_next;
  logic [ROUND_W-1:0] round_cnt;
  logic [WORD_W-1:0]  word_cnt;
  logic               last_word;

  assign last_word = (word_cnt == WORD_W'(`PKE_POLY_OUT_WORDS - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      round_cnt <= '0;
      word_cnt  <= '0;
    end else if (set) begin
      state <= state_next;
      if (state == START_CAL)
        round_cnt <= round_cnt + 1'b1;
      if (state == OUTPUT)
        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (ntt_done) state_next = READY_INPUT; // Block reports init done
      READY_INPUT: begin
        if (cbd_status == pke_enc_pkg::ST_OUTPUT_READY && ntt_cmd == pke_enc_pkg::CMD_RUN)
          state_next = INPUT;
      end
      INPUT:        if (cbd_status == pke_enc_pkg::ST_OUTPUT_DONE) state_next = START_CAL;
      START_CAL:    state_next = CALCULATE;
      CALCULATE:    if (ntt_done) state_next = OUTPUT_READY;
      OUTPUT_READY: if (sink_ready) state_next = OUTPUT; // External back-pressure
      OUTPUT:       if (last_word) state_next = OUTPUT_DONE;
      OUTPUT_DONE: begin
        if (round_cnt == ROUND_W'(`PKE_ENC_ROUNDS))
          state_next = SEQ_DONE;
        else if (ntt_cmd == pke_enc_pkg::CMD_RUN)
          state_next = IDLE;
      end
      default: state_next = state;
    endcase
  end

  always_comb begin
    ntt_status  = pke_enc_pkg::ST_IDLE;
    ntt_set     = 1'b0;
    ntt_readin  = 1'b0;
    ntt_cal_en  = 1'b0;
    ntt_readout = 1'b0;
    case (state)
      IDLE:         ntt_set = 1'b1;
      READY_INPUT:  ntt_status = pke_enc_pkg::ST_READY_INPUT;
      INPUT: begin
        ntt_status = pke_enc_pkg::ST_INPUT;
        ntt_readin = 1'b1;
      end
      START_CAL: begin
        ntt_status = pke_enc_pkg::ST_CALCULATE;
        ntt_cal_en = 1'b1; // Kick off the transform
      end
      CALCULATE:    ntt_status = pke_enc_pkg::ST_CALCULATE;
      OUTPUT_READY: ntt_status = pke_enc_pkg::ST_OUTPUT_READY;
      OUTPUT: begin
        ntt_status  = pke_enc_pkg::ST_OUTPUT;
        ntt_readout = 1'b1;
      end
      OUTPUT_DONE:  ntt_status = pke_enc_pkg::ST_OUTPUT_DONE;
      SEQ_DONE:     ntt_status = pke_enc_pkg::ST_SEQ_DONE;
      default:      ntt_status = pke_enc_pkg::ST_IDLE;
    endcase
  end

endmodule

//--- logic/cbd_stage_fsm.sv
`include "pke_enc_cfg.svh"

module cbd_stage_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set,
  input  pke_enc_pkg::ctrl_cmd_e     cbd_cmd,
  input  pke_enc_pkg::stage_status_e hash_status,
  input  pke_enc_pkg::stage_status_e ntt_status,
  input  logic                       cbd_ok_in,
  input  logic                       cbd_ok_out,
  output pke_enc_pkg::stage_status_e cbd_status,
  output logic                       cbd_set,
  output logic                       cbd_readin,
  output logic                       cbd_readout
);

  localparam int ROUND_W = $clog2(`PKE_ENC_ROUNDS + 1);

  typedef enum logic [3:0] {
    IDLE, READY_INPUT, INPUT, START_CAL, CALCULATE,
    OUTPUT_READY, OUTPUT, OUTPUT_DONE, SEQ_DONE
  } state_e;

  state_e             state;
  state_e             state_next;
  logic [ROUND_W-1:0] round_cnt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      round_cnt <= '0;
    end else if (set) begin
      state <= state_next;
      if (state == START_CAL)
        round_cnt <= round_cnt + 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (cbd_ok_in) state_next = READY_INPUT;
      READY_INPUT: begin
        // Hash burst is on the bus
        if (hash_status == pke_enc_pkg::ST_OUTPUT && cbd_cmd == pke_enc_pkg::CMD_RUN)
          state_next = INPUT;
      end
      INPUT:        if (hash_status == pke_enc_pkg::ST_OUTPUT_DONE) state_next = START_CAL;
      START_CAL:    state_next = CALCULATE;
      CALCULATE:    if (cbd_ok_out) state_next = OUTPUT_READY;
      OUTPUT_READY: if (ntt_status == pke_enc_pkg::ST_READY_INPUT) state_next = OUTPUT;
      OUTPUT:       if (!cbd_ok_out) state_next = OUTPUT_DONE; // Sampler drained
      OUTPUT_DONE: begin
        if (round_cnt == ROUND_W'(`PKE_ENC_ROUNDS))
          state_next = SEQ_DONE;
        else if (cbd_cmd == pke_enc_pkg::CMD_RUN)
          state_next = IDLE;
      end
      default: state_next = state;
    endcase
  end

  always_comb begin
    cbd_status  = pke_enc_pkg::ST_IDLE;
    cbd_set     = 1'b0;
    cbd_readin  = 1'b0;
    cbd_readout = 1'b0;
    case (state)
      IDLE:         cbd_set = 1'b1;
      READY_INPUT:  cbd_status = pke_enc_pkg::ST_READY_INPUT;
      INPUT: begin
        cbd_status = pke_enc_pkg::ST_INPUT;
        cbd_readin = 1'b1;
      end
      START_CAL,
      CALCULATE:    cbd_status = pke_enc_pkg::ST_CALCULATE;
      OUTPUT_READY: cbd_status = pke_enc_pkg::ST_OUTPUT_READY; // Holding samples for NTT
      OUTPUT: begin
        cbd_status  = pke_enc_pkg::ST_OUTPUT;
        cbd_readout = 1'b1;
      end
      OUTPUT_DONE:  cbd_status = pke_enc_pkg::ST_OUTPUT_DONE;
      SEQ_DONE:     cbd_status = pke_enc_pkg::ST_SEQ_DONE;
      default:      cbd_status = pke_enc_pkg::ST_IDLE;
    endcase
  end

endmodule

//--- logic/hash_stage_fsm.sv
`include "pke_enc_cfg.svh"

module hash_stage_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set,
  input  pke_enc_pkg::ctrl_cmd_e     hash_cmd,
  input  pke_enc_pkg::input_status_e seed_status,
  input  pke_enc_pkg::stage_status_e cbd_status,
  input  logic                       hash_readin_ok,
  input  logic                       hash_done,
  output pke_enc_pkg::stage_status_e hash_status,
  output logic                       hash_set,
  output logic                       hash_readin,
  output logic                       hash_full_in,
  output logic                       hash_readout
);

  localparam int ROUND_W = $clog2(`PKE_ENC_ROUNDS + 1);
  localparam int WORD_W  = $clog2(`PKE_HASH_OUT_WORDS);

  typedef enum logic [3:0] {
    IDLE, READY_INPUT, INPUT, START_CAL, CALCULATE,
    OUTPUT_READY, OUTPUT, OUTPUT_DONE, SEQ_DONE
  } state_e;

  state_e             state;
  state_e             state_next;
  logic [ROUND_W-1:0] round_cnt;
  logic [WORD_W-1:0]  word_cnt;
  logic               last_word;
  logic               last_round;

  assign last_word  = (word_cnt == WORD_W'(`PKE_HASH_OUT_WORDS - 1));
  assign last_round = (round_cnt == ROUND_W'(`PKE_ENC_ROUNDS));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      round_cnt <= '0;
      word_cnt  <= '0;
    end else if (set) begin
      state <= state_next;
      if (state == START_CAL)
        round_cnt <= round_cnt + 1'b1;
      if (state == OUTPUT)
        word_cnt <= last_word ? '0 : word_cnt + 1'b1; // Burst word index
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (hash_readin_ok) state_next = READY_INPUT; // Wait for block init
      READY_INPUT: begin
        if (seed_status == pke_enc_pkg::IN_STAGED && hash_cmd == pke_enc_pkg::CMD_RUN)
          state_next = INPUT;
      end
      INPUT:        if (seed_status == pke_enc_pkg::IN_DONE) state_next = START_CAL;
      START_CAL:    state_next = CALCULATE;
      CALCULATE:    if (hash_done) state_next = OUTPUT_READY;
      OUTPUT_READY: if (cbd_status == pke_enc_pkg::ST_READY_INPUT) state_next = OUTPUT;
      OUTPUT:       if (last_word) state_next = OUTPUT_DONE;
      OUTPUT_DONE: begin
        if (last_round)
          state_next = SEQ_DONE;
        else if (hash_cmd == pke_enc_pkg::CMD_RUN)
          state_next = START_CAL; // Next round reuses the absorbed seed
      end
      default: state_next = state;
    endcase
  end

  always_comb begin
    hash_status  = pke_enc_pkg::ST_IDLE;
    hash_set     = 1'b0;
    hash_readin  = 1'b0;
    hash_full_in = 1'b0;
    hash_readout = 1'b0;
    case (state)
      IDLE:         hash_set = 1'b1;
      READY_INPUT:  hash_status = pke_enc_pkg::ST_READY_INPUT;
      INPUT: begin
        hash_status = pke_enc_pkg::ST_INPUT;
        hash_readin = 1'b1;
      end
      START_CAL: begin
        hash_status  = pke_enc_pkg::ST_CALCULATE;
        hash_full_in = 1'b1;
      end
      CALCULATE:    hash_status = pke_enc_pkg::ST_CALCULATE;
      OUTPUT_READY: hash_status = pke_enc_pkg::ST_OUTPUT_READY;
      OUTPUT: begin
        hash_status  = pke_enc_pkg::ST_OUTPUT;
        hash_readout = 1'b1;
      end
      OUTPUT_DONE:  hash_status = pke_enc_pkg::ST_OUTPUT_DONE;
      SEQ_DONE:     hash_status = pke_enc_pkg::ST_SEQ_DONE;
      default:      hash_status = pke_enc_pkg::ST_IDLE;
    endcase
  end

endmodule

//--- logic/seed_input_fsm.sv
module seed_input_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set,
  input  pke_enc_pkg::ctrl_cmd_e     seed_cmd,
  input  pke_enc_pkg::stage_status_e hash_status,
  input  logic                       seed_full,
  output pke_enc_pkg::input_status_e seed_status,
  output pke_enc_pkg::input_type_e   input_type,
  output logic                       seed_load
);

  typedef enum logic [2:0] {
    IDLE,
    CHOOSE,
    STAGED,
    LOAD,
    ACTIVE,
    DONE
  } state_e;

  state_e state;
  state_e state_next;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= IDLE;
      input_type <= pke_enc_pkg::TYPE_NONE;
    end else if (set) begin
      state <= state_next;
      // Type is latched as the seed gets staged and kept for the run
      if (state == CHOOSE && seed_cmd == pke_enc_pkg::CMD_RUN)
        input_type <= pke_enc_pkg::TYPE_HASH_SEED;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (seed_cmd == pke_enc_pkg::CMD_HOLD) // Only choose after the command is cleared
          state_next = CHOOSE;
      end
      CHOOSE: if (seed_cmd == pke_enc_pkg::CMD_RUN) state_next = STAGED;
      STAGED: begin
        if (hash_status == pke_enc_pkg::ST_READY_INPUT)
          state_next = LOAD;
      end
      LOAD:   state_next = ACTIVE;
      ACTIVE: if (seed_full) state_next = DONE;
      DONE: begin
        if (hash_status == pke_enc_pkg::ST_CALCULATE) // Hash has taken the seed
          state_next = IDLE;
      end
      default: state_next = IDLE;
    endcase
  end

  always_comb begin
    seed_load   = 1'b0;
    seed_status = pke_enc_pkg::IN_IDLE;
    case (state)
      STAGED: seed_status = pke_enc_pkg::IN_STAGED;
      LOAD: begin
        seed_status = pke_enc_pkg::IN_STAGED;
        seed_load   = 1'b1; // One-cycle load pulse
      end
      ACTIVE:  seed_status = pke_enc_pkg::IN_ACTIVE;
      DONE:    seed_status = pke_enc_pkg::IN_DONE;
      default: seed_status = pke_enc_pkg::IN_IDLE;
    endcase
  end

endmodule

//--- logic/enc_sequencer.sv
module enc_sequencer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set,
  input  pke_enc_pkg::input_status_e seed_status,
  input  pke_enc_pkg::stage_status_e hash_status,
  input  pke_enc_pkg::stage_status_e cbd_status,
  input  pke_enc_pkg::stage_status_e ntt_status,
  output pke_enc_pkg::ctrl_cmd_e     seed_cmd,
  output pke_enc_pkg::ctrl_cmd_e     hash_cmd,
  output pke_enc_pkg::ctrl_cmd_e     cbd_cmd,
  output pke_enc_pkg::ctrl_cmd_e     ntt_cmd,
  output logic                       done
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } state_e;

  state_e state;
  state_e state_next;
  logic   seed_in; // Set once the seed is fully loaded

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= IDLE;
      seed_in <= 1'b0;
    end else if (set) begin
      state <= state_next;
      if (state == RUN && seed_status == pke_enc_pkg::IN_DONE)
        seed_in <= 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // Start only once every upstream controller reports idle
        if (seed_status == pke_enc_pkg::IN_IDLE && hash_status == pke_enc_pkg::ST_IDLE &&
            cbd_status == pke_enc_pkg::ST_IDLE)
          state_next = RUN;
      end
      RUN: if (ntt_status == pke_enc_pkg::ST_SEQ_DONE) state_next = FINISH;
      default: state_next = state; // FINISH parks
    endcase
  end

  assign seed_cmd = (state == RUN && !seed_in) ? pke_enc_pkg::CMD_RUN : pke_enc_pkg::CMD_HOLD;
  assign hash_cmd = (state != IDLE) ? pke_enc_pkg::CMD_RUN : pke_enc_pkg::CMD_HOLD;
  assign cbd_cmd  = (state != IDLE) ? pke_enc_pkg::CMD_RUN : pke_enc_pkg::CMD_HOLD;
  assign ntt_cmd  = (state != IDLE) ? pke_enc_pkg::CMD_RUN : pke_enc_pkg::CMD_HOLD;
  assign done     = (state == FINISH);

endmodule

//--- logic/pke_enc_pkg.sv
`include "pke_enc_cfg.svh"

package pke_enc_pkg;

  // Status reported by the hash, CBD and NTT stage controllers
  typedef enum logic [`PKE_CTRL_W-1:0] {
    ST_IDLE         = 0,
    ST_READY_INPUT  = 1,
    ST_INPUT        = 2,
    ST_CALCULATE    = 3,
    ST_OUTPUT_READY = 4,
    ST_OUTPUT       = 5,
    ST_OUTPUT_DONE  = 6,
    ST_SEQ_DONE     = 16  // Stage parked after its last round
  } stage_status_e;

  typedef enum logic [`PKE_CTRL_W-1:0] {
    IN_IDLE   = 0,
    IN_STAGED = 1,
    IN_ACTIVE = 2,
    IN_DONE   = 3
  } input_status_e;

  typedef enum logic [`PKE_CTRL_W-1:0] {
    CMD_HOLD = 0,
    CMD_RUN  = 1
  } ctrl_cmd_e;

  // Which block the seed randomness goes to
  typedef enum logic [`PKE_TYPE_W-1:0] {
    TYPE_NONE      = 0,
    TYPE_HASH_SEED = 1
  } input_type_e;

endpackage

//--- logic/pke_enc_cfg.svh
`ifndef PKE_ENC_CFG_SVH
`define PKE_ENC_CFG_SVH

// Rounds each stage runs before it parks
`define PKE_ENC_ROUNDS 3

`define PKE_HASH_OUT_WORDS 16  // Hash readout burst length in cycles
`define PKE_POLY_OUT_WORDS 128 // NTT readout burst length in cycles

// Control word widths
`define PKE_CTRL_W 8
`define PKE_TYPE_W 4

`endif
